// ==== src/hps_bridge_pkg.sv ====
// shared types and constants for the host-to-core bridge
// only the low byte of a command word is decoded
// the word index saturates at 31 on long frames
package hps_bridge_pkg;

	typedef logic [15:0] word_t;
	typedef logic [15:0] cmd_t;

	////////////////////////////////////////
	// user-I/O commands
	localparam cmd_t CMD_CFG        = 16'h0001;
	localparam cmd_t CMD_JOY0       = 16'h0002;
	localparam cmd_t CMD_JOY1       = 16'h0003;
	localparam cmd_t CMD_KBD        = 16'h0005;
	localparam cmd_t CMD_JOY2       = 16'h0010;
	localparam cmd_t CMD_JOY3       = 16'h0011;
	localparam cmd_t CMD_JOY4       = 16'h0012;
	localparam cmd_t CMD_JOY5       = 16'h0013;
	localparam cmd_t CMD_STATUS     = 16'h001E;
	localparam cmd_t CMD_STATUS_REQ = 16'h0029;

	// file channel commands
	localparam cmd_t CMD_FILE_TX    = 16'h0053;
	localparam cmd_t CMD_FILE_DATA  = 16'h0054;
	localparam cmd_t CMD_FILE_INDEX = 16'h0055;

	////////////////////////////////////////
	localparam int NUM_JOY    = 6;
	localparam int WORD_IDX_W = 5;

	// joystick n is addressed by JOY_CMD[n]
	localparam cmd_t JOY_CMD [NUM_JOY] = '{CMD_JOY0, CMD_JOY1, CMD_JOY2,
		CMD_JOY3, CMD_JOY4, CMD_JOY5};

	typedef logic [31:0]  joy_t;
	typedef logic [127:0] status_t;

	// toggle in 10, pressed in 9, extended in 8, scan code below
	typedef logic [10:0] ps2_key_t;

	localparam logic [7:0]  KEY_SKIP_MARK        = 8'hFF;
	localparam logic [31:0] KEY_PRNSCR_MAKE      = 32'hE012E07C;
	localparam logic [31:0] KEY_PRNSCR_BREAK     = 32'h7CE0F012;
	localparam logic [31:0] KEY_PAUSE_MAKE       = 32'hF014F077;
	localparam logic [9:0]  KEY_PRNSCR_MAKE_EVT  = 10'h37C;
	localparam logic [9:0]  KEY_PRNSCR_BREAK_EVT = 10'h17C;
	localparam logic [9:0]  KEY_PAUSE_MAKE_EVT   = 10'h377;

	localparam int FILE_ADDR_W = 27;
	typedef logic [7:0] file_byte_t;

	localparam logic [3:0] STATUS_REQ_TAG = 4'hA;

endpackage

// ==== src/host_frame_if.sv ====
// one channel's view of the framed host word stream
// cmd holds from the command word until frame_end
// rdata is the word the host reads at its next strobe
`timescale 1ns/1ps

interface host_frame_if;
	logic                                  active;
	hps_bridge_pkg::cmd_t                  cmd;
	logic [hps_bridge_pkg::WORD_IDX_W-1:0] word_idx;
	logic                                  word_valid;
	hps_bridge_pkg::word_t                 data;
	logic                                  frame_end;
	hps_bridge_pkg::word_t                 rdata;

	modport link (
		output active,
		output cmd,
		output word_idx,
		output word_valid,
		output data,
		output frame_end,
		input  rdata
	);

	modport chan (
		input  active,
		input  cmd,
		input  word_idx,
		input  word_valid,
		input  data,
		input  frame_end,
		output rdata
	);

endinterface

// ==== src/host_link.sv ====
// frame tracking shared by the user-I/O and file channels
// the host never raises both enables, so one data register serves both
// io_dout follows the raw enables and is zero between frames
`timescale 1ns/1ps

module host_link (
	input  logic                  clk_sys,
	input  logic                  arst_n,
	input  logic                  io_enable,
	input  logic                  fp_enable,
	input  logic                  io_strobe,
	input  hps_bridge_pkg::word_t io_din,
	output hps_bridge_pkg::word_t io_dout,
	host_frame_if.link            uio_link,
	host_frame_if.link            fio_link
);

	// channel 0 is user-I/O, channel 1 is file
	logic [1:0]                            en;
	logic [1:0]                            active_q;
	logic [1:0]                            valid_q;
	logic [1:0]                            end_q;
	hps_bridge_pkg::cmd_t                  cmd_q [2];
	logic [hps_bridge_pkg::WORD_IDX_W-1:0] cnt_q [2];
	logic [hps_bridge_pkg::WORD_IDX_W-1:0] idx_q [2];
	hps_bridge_pkg::word_t                 data_q;

	assign en = {fp_enable, io_enable};

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			active_q <= '0;
			valid_q  <= '0;
			end_q    <= '0;
			for (int ch = 0; ch < 2; ch++) begin
				cmd_q[ch] <= '0;
				cnt_q[ch] <= '0;
				idx_q[ch] <= '0;
			end
		end else begin
			for (int ch = 0; ch < 2; ch++) begin
				active_q[ch] <= en[ch];
				end_q[ch]    <= active_q[ch] & ~en[ch];
				valid_q[ch]  <= 1'b0;
				// command is released once frame_end has been seen
				if (end_q[ch])
					cmd_q[ch] <= '0;
				if (!en[ch]) begin
					cnt_q[ch] <= '0;
				end else if (io_strobe) begin
					if (cnt_q[ch] != '1)
						cnt_q[ch] <= cnt_q[ch] + 1'b1;
					if (cnt_q[ch] == '0) begin
						cmd_q[ch] <= io_din;
					end else begin
						valid_q[ch] <= 1'b1;
						idx_q[ch]   <= cnt_q[ch];
					end
				end
			end
		end
	end

	always_ff @(posedge clk_sys) begin
		if (io_strobe && (io_enable || fp_enable))
			data_q <= io_din;
	end

	assign uio_link.active     = active_q[0];
	assign uio_link.cmd        = cmd_q[0];
	assign uio_link.word_idx   = idx_q[0];
	assign uio_link.word_valid = valid_q[0];
	assign uio_link.data       = data_q;
	assign uio_link.frame_end  = end_q[0];

	assign fio_link.active     = active_q[1];
	assign fio_link.cmd        = cmd_q[1];
	assign fio_link.word_idx   = idx_q[1];
	assign fio_link.word_valid = valid_q[1];
	assign fio_link.data       = data_q;
	assign fio_link.frame_end  = end_q[1];

	assign io_dout = io_enable ? uio_link.rdata :
		fp_enable ? fio_link.rdata : '0;

endmodule

// ==== src/word_gather.sv ====
// builds a payload from consecutive 16-bit frame words
// word 1 fills the lowest slice, words past the payload are dropped
`timescale 1ns/1ps

module word_gather #(
	parameter type payload_t = hps_bridge_pkg::word_t
) (
	input  logic                                  clk_sys,
	input  logic                                  arst_n,
	input  logic                                  load,
	input  logic [hps_bridge_pkg::WORD_IDX_W-1:0] word_idx,
	input  hps_bridge_pkg::word_t                 data,
	output payload_t                              payload
);

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			payload <= '0;
		end else if (load && word_idx != '0 &&
				int'(word_idx) <= $bits(payload_t) / 16) begin
			payload[16 * (int'(word_idx) - 1) +: 16] <= data;
		end
	end

endmodule

// ==== src/ps2_key_decoder.sv ====
// turns the scan bytes of one keyboard frame into a key event
// kbd_frame must stay high through frame_end of a keyboard frame
// a skip word drops the whole frame's event
`timescale 1ns/1ps

module ps2_key_decoder (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  logic                     kbd_frame,
	input  logic                     word_valid,
	input  hps_bridge_pkg::word_t    data,
	input  logic                     frame_end,
	output hps_bridge_pkg::ps2_key_t ps2_key
);

	logic [31:0] raw;
	logic        skip;
	logic        is_skip;
	logic        pressed;
	logic        extended;
	logic [9:0]  evt;

	assign is_skip = data[15:8] == hps_bridge_pkg::KEY_SKIP_MARK;

	// raw bytes are cleared between keyboard frames
	always_ff @(posedge clk_sys) begin
		if (!kbd_frame)
			raw <= '0;
		else if (word_valid && !is_skip && !skip)
			raw <= {raw[23:0], data[7:0]};
	end

	// release is F0h then the code, E0h goes before either
	assign pressed  = raw[15:8] != 8'hF0;
	assign extended = pressed ? raw[15:8] == 8'hE0 : raw[23:16] == 8'hE0;

	always_comb begin
		evt = {pressed, extended, raw[7:0]};
		if (raw == hps_bridge_pkg::KEY_PRNSCR_MAKE)
			evt = hps_bridge_pkg::KEY_PRNSCR_MAKE_EVT;
		else if (raw == hps_bridge_pkg::KEY_PRNSCR_BREAK)
			evt = hps_bridge_pkg::KEY_PRNSCR_BREAK_EVT;
		else if (raw == hps_bridge_pkg::KEY_PAUSE_MAKE)
			evt = hps_bridge_pkg::KEY_PAUSE_MAKE_EVT;
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			skip    <= 1'b0;
			ps2_key <= '0;
		end else begin
			if (!kbd_frame)
				skip <= 1'b0;
			else if (word_valid && is_skip)
				skip <= 1'b1;
			if (frame_end && kbd_frame && !skip)
				ps2_key <= {~ps2_key[10], evt};
		end
	end

endmodule

// ==== src/uio_decoder.sv ====
// user-I/O channel: settings, joysticks, status, status requests, keyboard
// register writes land one cycle after word_valid
// status_in is captured on each status_set rising edge
// the request counter wraps at 16
`timescale 1ns/1ps

module uio_decoder (
	input  logic                     clk_sys,
	input  logic                     arst_n,
	input  hps_bridge_pkg::status_t  status_in,
	input  logic                     status_set,
	host_frame_if.chan               link,
	output logic [1:0]               buttons,
	output logic                     forced_scandoubler,
	output logic                     direct_video,
	output hps_bridge_pkg::joy_t     joystick_0,
	output hps_bridge_pkg::joy_t     joystick_1,
	output hps_bridge_pkg::joy_t     joystick_2,
	output hps_bridge_pkg::joy_t     joystick_3,
	output hps_bridge_pkg::joy_t     joystick_4,
	output hps_bridge_pkg::joy_t     joystick_5,
	output hps_bridge_pkg::status_t  status,
	output hps_bridge_pkg::ps2_key_t ps2_key
);

	logic [7:0]                            cmd_lo;
	hps_bridge_pkg::joy_t                  joy [hps_bridge_pkg::NUM_JOY];
	hps_bridge_pkg::word_t                 cfg;
	logic                                  status_set_q;
	logic [3:0]                            req_cnt;
	hps_bridge_pkg::status_t               status_req;
	logic [hps_bridge_pkg::WORD_IDX_W-1:0] rd_idx;
	logic [hps_bridge_pkg::WORD_IDX_W-1:0] rd_next;
	hps_bridge_pkg::word_t                 rd_word;
	hps_bridge_pkg::word_t                 rdata_q;

	assign cmd_lo = link.cmd[7:0];

	////////////////////////////////////////
	// multi-word targets
	for (genvar j = 0; j < hps_bridge_pkg::NUM_JOY; j++) begin : g_joy
		word_gather #(.payload_t(hps_bridge_pkg::joy_t)) u_joy (
			.clk_sys  (clk_sys),
			.arst_n   (arst_n),
			.load     (link.word_valid && cmd_lo == hps_bridge_pkg::JOY_CMD[j][7:0]),
			.word_idx (link.word_idx),
			.data     (link.data),
			.payload  (joy[j])
		);
	end

	word_gather #(.payload_t(hps_bridge_pkg::status_t)) u_status (
		.clk_sys  (clk_sys),
		.arst_n   (arst_n),
		.load     (link.word_valid && cmd_lo == hps_bridge_pkg::CMD_STATUS[7:0]),
		.word_idx (link.word_idx),
		.data     (link.data),
		.payload  (status)
	);

	ps2_key_decoder u_kbd (
		.clk_sys    (clk_sys),
		.arst_n     (arst_n),
		.kbd_frame  (cmd_lo == hps_bridge_pkg::CMD_KBD[7:0]),
		.word_valid (link.word_valid),
		.data       (link.data),
		.frame_end  (link.frame_end),
		.ps2_key    (ps2_key)
	);

	////////////////////////////////////////
	// settings word and status requests
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			cfg          <= '0;
			status_set_q <= 1'b0;
			req_cnt      <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q)
				req_cnt <= req_cnt + 1'b1;
			if (link.word_valid && cmd_lo == hps_bridge_pkg::CMD_CFG[7:0] &&
					link.word_idx == 1)
				cfg <= link.data;
		end
	end

	always_ff @(posedge clk_sys) begin
		if (status_set && !status_set_q)
			status_req <= status_in;
	end

	////////////////////////////////////////
	// read-back runs one word ahead of the host
	assign rd_next = link.word_valid ? link.word_idx + 1'b1 : rd_idx;

	always_comb begin
		rd_word = '0;
		if (cmd_lo == hps_bridge_pkg::CMD_STATUS_REQ[7:0]) begin
			if (rd_next == 1)
				rd_word = {8'h00, hps_bridge_pkg::STATUS_REQ_TAG, req_cnt};
			else if (rd_next >= 2 && rd_next <= 9)
				rd_word = status_req[16 * (int'(rd_next) - 2) +: 16];
		end
	end

	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			rd_idx  <= hps_bridge_pkg::WORD_IDX_W'(1);
			rdata_q <= '0;
		end else if (!link.active) begin
			rd_idx  <= hps_bridge_pkg::WORD_IDX_W'(1);
			rdata_q <= '0;
		end else begin
			rd_idx  <= rd_next;
			rdata_q <= rd_word;
		end
	end

	assign link.rdata = rdata_q;

	// cfg bits 2, 3 and 5 belong to the video frame and are not used here
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	assign joystick_0 = joy[0];
	assign joystick_1 = joy[1];
	assign joystick_2 = joy[2];
	assign joystick_3 = joy[3];
	assign joystick_4 = joy[4];
	assign joystick_5 = joy[5];

endmodule

// ==== src/file_loader.sv ====
// host-to-core download, 8-bit data only
// ioctl_wr comes two cycles after the data word's word_valid
// data words outside a download are dropped, upload requests are ignored
`timescale 1ns/1ps

module file_loader (
	input  logic                                   clk_sys,
	input  logic                                   arst_n,
	host_frame_if.chan                             link,
	output logic                                   ioctl_download,
	output hps_bridge_pkg::word_t                  ioctl_index,
	output logic                                   ioctl_wr,
	output logic [hps_bridge_pkg::FILE_ADDR_W-1:0] ioctl_addr,
	output hps_bridge_pkg::file_byte_t             ioctl_dout
);

	logic [7:0]                             cmd_lo;
	logic                                   tx_word;
	logic                                   data_word;
	logic                                   wr_q;
	logic [hps_bridge_pkg::FILE_ADDR_W-1:0] addr;

	assign cmd_lo    = link.cmd[7:0];
	assign tx_word   = link.word_valid && cmd_lo == hps_bridge_pkg::CMD_FILE_TX[7:0];
	assign data_word = link.word_valid && ioctl_download &&
		cmd_lo == hps_bridge_pkg::CMD_FILE_DATA[7:0];

	// nothing is read back on this channel
	assign link.rdata = '0;

	////////////////////////////////////////
	// download control and address counter
	always_ff @(posedge clk_sys or negedge arst_n) begin
		if (!arst_n) begin
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_wr       <= 1'b0;
			wr_q           <= 1'b0;
			addr           <= '0;
		end else begin
			wr_q     <= data_word;
			ioctl_wr <= wr_q;

			if (link.word_valid && link.word_idx == 1 &&
					cmd_lo == hps_bridge_pkg::CMD_FILE_INDEX[7:0])
				ioctl_index <= link.data;

			if (tx_word) begin
				if (link.word_idx == 1) begin
					// AAh would be an upload
					if (link.data[7:0] == 8'h00) begin
						ioctl_download <= 1'b0;
					end else if (link.data[7:0] != 8'hAA) begin
						ioctl_download <= 1'b1;
						addr           <= '0;
					end
				end else if (link.word_idx == 2) begin
					addr[15:0] <= link.data;
				end else if (link.word_idx == 3) begin
					addr[hps_bridge_pkg::FILE_ADDR_W-1:16] <=
						link.data[hps_bridge_pkg::FILE_ADDR_W-17:0];
				end
			end

			if (data_word)
				addr <= addr + 1'b1;
		end
	end

	// address and byte held from the cycle before the write pulse
	always_ff @(posedge clk_sys) begin
		if (data_word) begin
			ioctl_addr <= addr;
			ioctl_dout <= link.data[7:0];
		end
	end

endmodule

// ==== src/hps_bridge_top.sv ====
// host-to-core bridge top level
// the host must hold io_strobe low while host_wait is high
// nothing is buffered, ioctl_wait is the only back-pressure
`timescale 1ns/1ps

module hps_bridge_top (
	input  logic                                   clk_sys,
	input  logic                                   arst_n,
	input  logic                                   io_enable,
	input  logic                                   fp_enable,
	input  logic                                   io_strobe,
	input  hps_bridge_pkg::word_t                  io_din,
	input  logic                                   ioctl_wait,
	input  hps_bridge_pkg::status_t                status_in,
	input  logic                                   status_set,
	output hps_bridge_pkg::word_t                  io_dout,
	output logic                                   host_wait,
	output logic [1:0]                             buttons,
	output logic                                   forced_scandoubler,
	output logic                                   direct_video,
	output hps_bridge_pkg::joy_t                   joystick_0,
	output hps_bridge_pkg::joy_t                   joystick_1,
	output hps_bridge_pkg::joy_t                   joystick_2,
	output hps_bridge_pkg::joy_t                   joystick_3,
	output hps_bridge_pkg::joy_t                   joystick_4,
	output hps_bridge_pkg::joy_t                   joystick_5,
	output hps_bridge_pkg::status_t                status,
	output hps_bridge_pkg::ps2_key_t               ps2_key,
	output logic                                   ioctl_download,
	output hps_bridge_pkg::word_t                  ioctl_index,
	output logic                                   ioctl_wr,
	output logic [hps_bridge_pkg::FILE_ADDR_W-1:0] ioctl_addr,
	output hps_bridge_pkg::file_byte_t             ioctl_dout
);

	host_frame_if uio_if ();
	host_frame_if fio_if ();

	assign host_wait = ioctl_wait;

	host_link u_link (
		.clk_sys   (clk_sys),
		.arst_n    (arst_n),
		.io_enable (io_enable),
		.fp_enable (fp_enable),
		.io_strobe (io_strobe),
		.io_din    (io_din),
		.io_dout   (io_dout),
		.uio_link  (uio_if.link),
		.fio_link  (fio_if.link)
	);

	uio_decoder u_uio (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.status_in          (status_in),
		.status_set         (status_set),
		.link               (uio_if.chan),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.joystick_2         (joystick_2),
		.joystick_3         (joystick_3),
		.joystick_4         (joystick_4),
		.joystick_5         (joystick_5),
		.status             (status),
		.ps2_key            (ps2_key)
	);

	file_loader u_file (
		.clk_sys        (clk_sys),
		.arst_n         (arst_n),
		.link           (fio_if.chan),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

endmodule

// ==== tests/tb_clock_gen.sv ====
// free-running testbench clock and power-on reset
// arst_n is released 1 ns after the third rising edge
`timescale 1ns/1ps

module tb_clock_gen #(
	parameter int PERIOD_NS = 4
) (
	output logic clk_sys,
	output logic arst_n
);

	initial begin
		clk_sys = 1'b0;
		forever #(PERIOD_NS / 2.0) clk_sys = ~clk_sys;
	end

	initial begin
		arst_n = 1'b0;
		repeat (3) @(posedge clk_sys);
		#1;
		arst_n = 1'b1;
	end

endmodule

// ==== tests/hps_bridge_properties.sv ====
// host-side protocol checks, bound into the bridge top level
// they watch the host_link and file_loader ports
// all checks are off while arst_n is low
`timescale 1ns/1ps

module hps_bridge_properties (
	input logic                  clk_sys,
	input logic                  arst_n,
	input logic                  io_enable,
	input logic                  fp_enable,
	input logic                  io_strobe,
	input logic                  host_wait,
	input hps_bridge_pkg::word_t io_dout,
	input logic                  ioctl_download,
	input logic                  ioctl_wr
);

	// one channel framed at a time
	one_channel: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(io_enable && fp_enable))
		else $error("io_enable and fp_enable are high together");

	wr_in_download: assert property (@(posedge clk_sys) disable iff (!arst_n)
		ioctl_wr |-> ioctl_download)
		else $error("ioctl_wr pulsed outside a download");

	// a strobe during wait is a host error
	no_strobe_in_wait: assert property (@(posedge clk_sys) disable iff (!arst_n)
		io_strobe |-> !host_wait)
		else $error("io_strobe came while host_wait was high");

	idle_dout_zero: assert property (@(posedge clk_sys) disable iff (!arst_n)
		!(io_enable || fp_enable) |-> io_dout == '0)
		else $error("io_dout is not zero outside a frame");

endmodule

bind hps_bridge_top hps_bridge_properties u_props (
	.clk_sys        (clk_sys),
	.arst_n         (arst_n),
	.io_enable      (io_enable),
	.fp_enable      (fp_enable),
	.io_strobe      (io_strobe),
	.host_wait      (host_wait),
	.io_dout        (io_dout),
	.ioctl_download (ioctl_download),
	.ioctl_wr       (ioctl_wr)
);

// ==== tests/tb_hps_bridge.sv ====
// testbench for the host-to-core bridge
// each line of tests/hps_bridge_tests.txt is one frame or one status_set edge
// frames carry one strobe every 4 cycles
// ioctl_wait is held high for a few cycles before each frame
// run from the project root so the test file is found
`timescale 1ns/1ps

module tb_hps_bridge;

	localparam int    CLK_NS          = 4;
	localparam int    CYCLES_PER_TEST = 200;
	localparam int    MAX_WORDS       = 16;
	localparam int    ADDR_W          = hps_bridge_pkg::FILE_ADDR_W;
	localparam string TEST_FILE       = "tests/hps_bridge_tests.txt";

	logic                       clk_sys;
	logic                       arst_n;
	logic                       io_enable;
	logic                       fp_enable;
	logic                       io_strobe;
	hps_bridge_pkg::word_t      io_din;
	logic                       ioctl_wait;
	hps_bridge_pkg::status_t    status_in;
	logic                       status_set;
	hps_bridge_pkg::word_t      io_dout;
	logic                       host_wait;
	logic [1:0]                 buttons;
	logic                       forced_scandoubler;
	logic                       direct_video;
	hps_bridge_pkg::joy_t       joy [hps_bridge_pkg::NUM_JOY];
	hps_bridge_pkg::status_t    status;
	hps_bridge_pkg::ps2_key_t   ps2_key;
	logic                       ioctl_download;
	hps_bridge_pkg::word_t      ioctl_index;
	logic                       ioctl_wr;
	logic [ADDR_W-1:0]          ioctl_addr;
	hps_bridge_pkg::file_byte_t ioctl_dout;

	integer                     fd;
	integer                     code;
	integer                     seed;
	int                         num_tests = 0;
	int                         test_cnt;
	int                         err_cnt;
	int                         test_errs;
	int                         data_words;
	int                         wr_total = 0;
	int                         n_words;
	string                      name;
	string                      chk;
	hps_bridge_pkg::cmd_t       cmd;
	hps_bridge_pkg::word_t      words    [MAX_WORDS];
	hps_bridge_pkg::word_t      rd_words [MAX_WORDS];
	logic [127:0]               exp_val  [MAX_WORDS];
	logic [ADDR_W-1:0]          wr_addr_q [$];
	hps_bridge_pkg::file_byte_t wr_data_q [$];

	tb_clock_gen #(.PERIOD_NS(CLK_NS)) u_clk (
		.clk_sys (clk_sys),
		.arst_n  (arst_n)
	);

	hps_bridge_top dut0 (
		.clk_sys            (clk_sys),
		.arst_n             (arst_n),
		.io_enable          (io_enable),
		.fp_enable          (fp_enable),
		.io_strobe          (io_strobe),
		.io_din             (io_din),
		.ioctl_wait         (ioctl_wait),
		.status_in          (status_in),
		.status_set         (status_set),
		.io_dout            (io_dout),
		.host_wait          (host_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joy[0]),
		.joystick_1         (joy[1]),
		.joystick_2         (joy[2]),
		.joystick_3         (joy[3]),
		.joystick_4         (joy[4]),
		.joystick_5         (joy[5]),
		.status             (status),
		.ps2_key            (ps2_key),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	// every write pulse is recorded mid-cycle
	always @(negedge clk_sys) begin
		if (arst_n && ioctl_wr) begin
			wr_addr_q.push_back(ioctl_addr);
			wr_data_q.push_back(ioctl_dout);
			wr_total++;
		end
	end

	////////////////////////////////////////
	// file reading

	function automatic string packed_to_text(input logic [8*32-1:0] v);
		string s;
		s = "";
		for (int i = 31; i >= 0; i--) begin
			if (v[8*i +: 8] != 8'h00)
				s = $sformatf("%s%c", s, v[8*i +: 8]);
		end
		return s;
	endfunction

	task automatic read_token(output string s, output bit ok);
		logic [8*32-1:0] tok;
		tok = '0;
		ok = $fscanf(fd, "%s", tok) == 1;
		s = packed_to_text(tok);
	endtask

	// comment lines start with #
	task automatic next_name(output string s, output bit ok);
		logic [8*256-1:0] line;
		read_token(s, ok);
		while (ok && s[0] == "#") begin
			code = $fgets(line, fd);
			read_token(s, ok);
		end
	endtask

	task automatic read_body(output bit ok);
		bit got;
		int n_exp;
		got = 1'b0;
		ok = ($fscanf(fd, "%h %d", cmd, n_words) == 2) && n_words <= MAX_WORDS;
		if (ok) begin
			for (int i = 0; i < n_words; i++)
				code = $fscanf(fd, "%h", words[i]);
			read_token(chk, got);
			n_exp = chk == "rdback" ? n_words : chk == "joys" ? hps_bridge_pkg::NUM_JOY :
				chk == "file" ? 3 : 1;
			for (int i = 0; i < n_exp; i++)
				code = $fscanf(fd, "%h", exp_val[i]);
		end
		ok = ok && got;
	endtask

	task automatic count_tests();
		logic [8*256-1:0] line;
		string s;
		bit ok;
		next_name(s, ok);
		while (ok) begin
			code = $fgets(line, fd);
			num_tests++;
			next_name(s, ok);
		end
	endtask

	////////////////////////////////////////
	// host side driving

	task automatic next_cycle();
		@(posedge clk_sys);
		#1;
	endtask

	task automatic value_error(input string what, input logic [127:0] exp,
			input logic [127:0] act);
		$display("CHECK FAILED %s %s: expected %0h, actual %0h", name, what, exp, act);
		err_cnt++;
		test_errs++;
	endtask

	task automatic check_idle_dout();
		@(negedge clk_sys);
		if (io_dout !== '0)
			value_error("io_dout between frames", '0, 128'(io_dout));
		next_cycle();
	endtask

	// core back-pressure must show on host_wait while it lasts
	task automatic hold_core_wait(input int cycles);
		ioctl_wait = 1'b1;
		@(negedge clk_sys);
		if (host_wait !== 1'b1)
			value_error("host_wait during ioctl_wait", 128'(1), 128'(host_wait));
		repeat (cycles) next_cycle();
		ioctl_wait = 1'b0;
		@(negedge clk_sys);
		if (host_wait !== 1'b0)
			value_error("host_wait after ioctl_wait", '0, 128'(host_wait));
		next_cycle();
	endtask

	// strobe for one cycle, then two quiet cycles
	task automatic send_word(input hps_bridge_pkg::word_t w);
		io_din    = w;
		io_strobe = 1'b1;
		next_cycle();
		io_strobe = 1'b0;
		repeat (2) next_cycle();
	endtask

	task automatic drive_frame(input bit file_chan);
		int gap;
		gap = $unsigned($random(seed)) % 4;
		hold_core_wait(1 + gap);
		while (host_wait)
			next_cycle();
		if (file_chan)
			fp_enable = 1'b1;
		else
			io_enable = 1'b1;
		send_word(cmd);
		for (int i = 0; i < n_words; i++) begin
			// read-back word is taken just before the next strobe
			@(negedge clk_sys);
			rd_words[i] = io_dout;
			next_cycle();
			while (host_wait)
				next_cycle();
			send_word(words[i]);
		end
		next_cycle();
		io_enable = 1'b0;
		fp_enable = 1'b0;
		repeat (4 + gap) next_cycle();
		check_idle_dout();
	endtask

	task automatic pulse_status_set(input hps_bridge_pkg::status_t value);
		status_in  = value;
		status_set = 1'b1;
		next_cycle();
		status_set = 1'b0;
		repeat (2) next_cycle();
		check_idle_dout();
	endtask

	////////////////////////////////////////
	// checks against the file's values

	task automatic check_outputs();
		logic [ADDR_W-1:0] exp_addr;
		if (chk == "joys") begin
			for (int j = 0; j < hps_bridge_pkg::NUM_JOY; j++) begin
				if (joy[j] !== exp_val[j][31:0])
					value_error($sformatf("joystick_%0d", j), exp_val[j], 128'(joy[j]));
			end
		end else if (chk == "cfg") begin
			if ({direct_video, forced_scandoubler, buttons} !== exp_val[0][3:0])
				value_error("cfg outputs", exp_val[0],
					128'({direct_video, forced_scandoubler, buttons}));
		end else if (chk == "status") begin
			if (status !== exp_val[0])
				value_error("status", exp_val[0], status);
		end else if (chk == "key") begin
			if (ps2_key !== exp_val[0][10:0])
				value_error("ps2_key", exp_val[0], 128'(ps2_key));
		end else if (chk == "rdback") begin
			for (int i = 0; i < n_words; i++) begin
				if (rd_words[i] !== exp_val[i][15:0])
					value_error($sformatf("io_dout word %0d", i + 1), exp_val[i],
						128'(rd_words[i]));
			end
		end else if (chk == "index") begin
			if (ioctl_index !== exp_val[0][15:0])
				value_error("ioctl_index", exp_val[0], 128'(ioctl_index));
		end else if (chk == "file") begin
			if (ioctl_download !== exp_val[0][0])
				value_error("ioctl_download", exp_val[0], 128'(ioctl_download));
			if (wr_addr_q.size() != int'(exp_val[1][15:0])) begin
				value_error("ioctl_wr pulses", exp_val[1], 128'(wr_addr_q.size()));
			end else begin
				// one byte per data word, addresses count up
				for (int i = 0; i < wr_addr_q.size(); i++) begin
					exp_addr = exp_val[2][ADDR_W-1:0] + ADDR_W'(i);
					if (wr_addr_q[i] !== exp_addr)
						value_error("ioctl_addr", 128'(exp_addr), 128'(wr_addr_q[i]));
					if (wr_data_q[i] !== words[i][7:0])
						value_error("ioctl_dout", 128'(words[i][7:0]), 128'(wr_data_q[i]));
				end
			end
		end else if (chk != "stset") begin
			$display("test %s names an unknown check %s", name, chk);
			err_cnt++;
			test_errs++;
		end
	endtask

	task automatic run_one_test();
		bit file_chan;
		file_chan = cmd[7:0] == hps_bridge_pkg::CMD_FILE_TX[7:0] ||
			cmd[7:0] == hps_bridge_pkg::CMD_FILE_DATA[7:0] ||
			cmd[7:0] == hps_bridge_pkg::CMD_FILE_INDEX[7:0];
		test_errs = 0;
		wr_addr_q.delete();
		wr_data_q.delete();
		if (chk == "stset")
			pulse_status_set(exp_val[0]);
		else
			drive_frame(file_chan);
		if (cmd[7:0] == hps_bridge_pkg::CMD_FILE_DATA[7:0])
			data_words += n_words;
		check_outputs();
		test_cnt++;
		$display("test %s done with %0d errors", name, test_errs);
	endtask

	////////////////////////////////////////
	// main sequence and watchdog

	initial begin
		bit ok;
		seed       = 32'h62128642;
		io_enable  = 1'b0;
		fp_enable  = 1'b0;
		io_strobe  = 1'b0;
		io_din     = '0;
		ioctl_wait = 1'b0;
		status_in  = '0;
		status_set = 1'b0;
		err_cnt    = 0;
		test_cnt   = 0;
		data_words = 0;
		fd = $fopen(TEST_FILE, "r");
		if (fd == 0) begin
			$display("cannot open the test file %s", TEST_FILE);
			$display("Simulation failed");
			$finish;
		end else begin
			count_tests();
			$fclose(fd);
			if (num_tests == 0) begin
				$display("the test file holds no tests");
				err_cnt++;
			end
			fd = $fopen(TEST_FILE, "r");
			wait (arst_n === 1'b1);
			next_cycle();
			next_name(name, ok);
			while (ok) begin
				read_body(ok);
				if (ok) begin
					run_one_test();
				end else begin
					$display("test %s has a malformed line in the test file", name);
					err_cnt++;
				end
				next_name(name, ok);
			end
			$fclose(fd);
			if (wr_total != data_words) begin
				$display("%0d write pulses seen for %0d data words", wr_total, data_words);
				err_cnt++;
			end
			$display("tests run: %0d of %0d, failed checks: %0d, write pulses: %0d",
				test_cnt, num_tests, err_cnt, wr_total);
			if (err_cnt == 0)
				$display("Simulation passed");
			else
				$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		wait (num_tests > 0);
		#(num_tests * CYCLES_PER_TEST * CLK_NS);
		$display("timeout: the tests did not finish within %0d cycles",
			num_tests * CYCLES_PER_TEST);
		$display("Simulation failed");
		$finish;
	end

endmodule

// ==== tests/hps_bridge_tests.txt ====
# name cmd(hex) word_count words(hex) check expected(hex)
# joys: joystick 0..5, cfg: {direct_video,forced_scandoubler,buttons}, file: download wr_count first_addr
joy0_words 02 2 1234 ABCD joys ABCD1234 0 0 0 0 0
joy3_words 11 2 5555 00F0 joys ABCD1234 0 0 00F05555 0 0
joy5_words 13 2 FFFF 8001 joys ABCD1234 0 0 00F05555 0 8001FFFF
cfg_all_set 01 1 0413 cfg F
cfg_buttons 01 1 0002 cfg 2
status_words 1E 8 1111 2222 3333 4444 5555 6666 7777 8888 status 88887777666655554444333322221111
status_edge_a 00 0 stset 0000000000000000000000000000BEEF
status_edge_b 00 0 stset 0123456789ABCDEF0F1E2D3C4B5A6978
status_req 29 9 0 0 0 0 0 0 0 0 0 rdback 00A2 6978 4B5A 2D3C 0F1E CDEF 89AB 4567 0123
key_make 05 1 001C key 61C
key_release 05 2 00F0 001C key 01C
key_ext_make 05 2 00E0 0075 key 775
key_ext_release 05 3 00E0 00F0 0075 key 175
key_prnscr_make 05 4 00E0 0012 00E0 007C key 77C
key_prnscr_break 05 6 00E0 00F0 007C 00E0 00F0 0012 key 17C
key_pause_make 05 8 00E1 0014 0077 00E1 00F0 0014 00F0 0077 key 777
key_skip 05 2 001C FF00 key 777
file_index 55 1 0003 index 0003
tx_start 53 3 0001 0100 0000 file 1 0 0
data_a 54 4 00A5 005A 1234 FF00 file 1 4 100
data_b 54 2 0011 0022 file 1 2 104
tx_stop 53 1 0000 file 0 0 0

// ==== build.f ====
src/hps_bridge_pkg.sv
src/host_frame_if.sv
src/host_link.sv
src/word_gather.sv
src/ps2_key_decoder.sv
src/uio_decoder.sv
src/file_loader.sv
src/hps_bridge_top.sv
tests/tb_clock_gen.sv
tests/hps_bridge_properties.sv
tests/tb_hps_bridge.sv

// ==== run_sim.sh ====
#!/bin/sh
# compile and run the bridge testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_hps_bridge -f build.f
if [ $? -ne 0 ]; then
	echo "Verilator compile failed"
	exit 1
fi

out=$(./obj_dir/Vtb_hps_bridge)
sim_status=$?
printf '%s\n' "$out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if printf '%s\n' "$out" | grep -qx "Simulation passed"; then
	exit 0
fi
exit 1
